// File: hw/soc_ctrl_bus_pkg.sv
package soc_ctrl_bus_pkg;

   // the register bus addresses bytes inside a 256-byte window
   parameter int unsigned REG_ADDR_WIDTH = 8;

   // every register is one 32-bit word
   parameter int unsigned REG_DATA_WIDTH = 32;

   // number of low address bits that must be zero for a word access
   parameter int unsigned REG_ADDR_LSB = $clog2(REG_DATA_WIDTH / 8);

   // byte offset of a register inside the window
   typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

   // one register data word, used for both directions of the bus
   typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;

endpackage

// File: hw/soc_ctrl_reg_pkg.sv
package soc_ctrl_reg_pkg;

   import soc_ctrl_bus_pkg::*;

   // register map, all other offsets inside the window are unmapped
   parameter reg_addr_t CTRL_CLUSTER_OFFSET = 8'h00;
   parameter reg_addr_t GWT_WRITE_OFFSET    = 8'h04;
   parameter reg_addr_t GWT_READ_OFFSET     = 8'h08;

   // each key spans four consecutive words starting at its base
   parameter reg_addr_t KEY0_BASE_OFFSET    = 8'h10;
   parameter reg_addr_t KEY1_BASE_OFFSET    = 8'h20;

   // bit positions inside the cluster control register
   parameter int unsigned CLUSTER_RSTN_BIT = 0;
   parameter int unsigned EN_SA_BOOT_BIT   = 1;
   parameter int unsigned FETCH_EN_BIT     = 2;

   // a locking key is built from this many register words
   parameter int unsigned KEY_WORDS = 4;

   // width of the word index inside one key
   parameter int unsigned KEY_IDX_WIDTH = $clog2(KEY_WORDS);

   // first address bit above the word index of a key, the bases are aligned to it
   parameter int unsigned KEY_BASE_LSB = KEY_IDX_WIDTH + REG_ADDR_LSB;

   // word 0 sits at the lowest offset and ends up in bits 31:0
   typedef logic [KEY_WORDS-1:0][REG_DATA_WIDTH-1:0] key_t;

   // everything resets to zero, so the cluster starts held in reset
   parameter reg_data_t CTRL_CLUSTER_RESET = '0;
   parameter reg_data_t GWT_WRITE_RESET    = '0;
   parameter reg_data_t GWT_READ_RESET     = '0;
   parameter key_t      KEY_RESET          = '0;

endpackage

// File: hw/reg_bus_if.sv
`timescale 1ns/1ns

interface reg_bus_if
   import soc_ctrl_bus_pkg::*;
(
   input logic clk_i
);

   // request, valid for a single cycle with no back-pressure
   logic      valid;
   logic      write;
   reg_addr_t addr;
   reg_data_t wdata;

   // response, returned in the same cycle as valid
   reg_data_t rdata;
   logic      error;

   modport requester (
      input  clk_i,
      output valid,
      output write,
      output addr,
      output wdata,
      input  rdata,
      input  error
   );

   modport completer (
      input  clk_i,
      input  valid,
      input  write,
      input  addr,
      input  wdata,
      output rdata,
      output error
   );

endinterface

// File: hw/apb_to_reg_bridge.sv
`timescale 1ns/1ns

module apb_to_reg_bridge
   import soc_ctrl_bus_pkg::*;
#(
   parameter int unsigned APB_ADDR_WIDTH = 32
) (
   input  logic                      clk_i,
   input  logic                      rst_n_i,

   input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  logic                      pwrite_i,
   input  reg_data_t                 pwdata_i,
   output reg_data_t                 prdata_o,
   output logic                      pready_o,
   output logic                      pslverr_o,

   reg_bus_if.requester              reg_o
);

   logic      access;
   logic      start;
   logic      aligned;
   logic      in_window;
   logic      addr_ok;
   logic      issued_q;
   logic      pready_q;
   logic      pslverr_q;
   reg_data_t prdata_q;

   // access phase of an APB transfer
   assign access = psel_i & penable_i;

   // first cycle of the access phase, the only one that may issue a strobe
   assign start = access & ~issued_q;

   // the register bus only sees word accesses inside its own window
   assign aligned   = (paddr_i[REG_ADDR_LSB-1:0] == '0);
   assign in_window = ((paddr_i >> REG_ADDR_WIDTH) == '0);
   assign addr_ok   = aligned & in_window;

   assign reg_o.valid = start & addr_ok;
   assign reg_o.write = pwrite_i;
   assign reg_o.addr  = paddr_i[REG_ADDR_WIDTH-1:0];
   assign reg_o.wdata = pwdata_i;

   // issued_q stays set for the rest of the access phase and drops with the next setup cycle
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         issued_q  <= 1'b0;
         pready_q  <= 1'b0;
         pslverr_q <= 1'b0;
      end else begin
         issued_q <= access;
         // the response is presented exactly one cycle after the strobe cycle
         pready_q  <= start;
         pslverr_q <= start & (~addr_ok | reg_o.error);
      end
   end

   // a rejected address never reaches the register file and returns zero data
   always_ff @(posedge clk_i) begin
      if (start) begin
         prdata_q <= addr_ok ? reg_o.rdata : '0;
      end
   end

   assign prdata_o  = prdata_q;
   assign pready_o  = pready_q;
   assign pslverr_o = pslverr_q;

endmodule

// File: hw/soc_ctrl_regfile.sv
`timescale 1ns/1ns

module soc_ctrl_regfile
   import soc_ctrl_bus_pkg::*;
   import soc_ctrl_reg_pkg::*;
(
   input  logic               clk_i,
   input  logic               rst_n_i,

   reg_bus_if.completer       reg_i,

   output logic               cluster_ctrl_rstn_o,
   output logic               cluster_en_sa_boot_o,
   output logic               cluster_fetch_en_o,

   output key_t               key_0_o,
   output key_t               key_1_o,

   output reg_data_t          gwt_cfg_o,
   input  reg_data_t          gwt_cfg_i,
   input  logic               gwt_cfg_ie_i
);

   logic                     hit_ctrl;
   logic                     hit_gwt_write;
   logic                     hit_gwt_read;
   logic                     hit_key0;
   logic                     hit_key1;
   logic                     mapped;
   logic                     bad_access;
   logic                     wr_en;
   logic [KEY_IDX_WIDTH-1:0] key_idx;

   logic                     cluster_rstn_q;
   logic                     en_sa_boot_q;
   logic                     fetch_en_q;
   reg_data_t                gwt_cfg_q;
   reg_data_t                gwt_status_q;
   key_t                     key0_q;
   key_t                     key1_q;

   // offsets arrive word aligned, the bridge rejects anything else
   assign hit_ctrl      = (reg_i.addr == CTRL_CLUSTER_OFFSET);
   assign hit_gwt_write = (reg_i.addr == GWT_WRITE_OFFSET);
   assign hit_gwt_read  = (reg_i.addr == GWT_READ_OFFSET);

   // key bases are aligned to the key size, so the upper bits select the key
   assign hit_key0 = (reg_i.addr[REG_ADDR_WIDTH-1:KEY_BASE_LSB] ==
                      KEY0_BASE_OFFSET[REG_ADDR_WIDTH-1:KEY_BASE_LSB]);
   assign hit_key1 = (reg_i.addr[REG_ADDR_WIDTH-1:KEY_BASE_LSB] ==
                      KEY1_BASE_OFFSET[REG_ADDR_WIDTH-1:KEY_BASE_LSB]);

   // and the lower bits select the word inside it
   assign key_idx = reg_i.addr[KEY_BASE_LSB-1:REG_ADDR_LSB];

   assign mapped = hit_ctrl | hit_gwt_write | hit_gwt_read | hit_key0 | hit_key1;

   // the status register belongs to hardware, software may only read it
   assign bad_access = ~mapped | (reg_i.write & hit_gwt_read);

   assign reg_i.error = bad_access;

   // a rejected access must leave every register untouched
   assign wr_en = reg_i.valid & reg_i.write & ~bad_access;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cluster_rstn_q <= CTRL_CLUSTER_RESET[CLUSTER_RSTN_BIT];
         en_sa_boot_q   <= CTRL_CLUSTER_RESET[EN_SA_BOOT_BIT];
         fetch_en_q     <= CTRL_CLUSTER_RESET[FETCH_EN_BIT];
         gwt_cfg_q      <= GWT_WRITE_RESET;
         key0_q         <= KEY_RESET;
         key1_q         <= KEY_RESET;
      end else if (wr_en) begin
         // only the three defined control bits are stored
         if (hit_ctrl) begin
            cluster_rstn_q <= reg_i.wdata[CLUSTER_RSTN_BIT];
            en_sa_boot_q   <= reg_i.wdata[EN_SA_BOOT_BIT];
            fetch_en_q     <= reg_i.wdata[FETCH_EN_BIT];
         end
         if (hit_gwt_write) begin
            gwt_cfg_q <= reg_i.wdata;
         end
         if (hit_key0) begin
            key0_q[key_idx] <= reg_i.wdata;
         end
         if (hit_key1) begin
            key1_q[key_idx] <= reg_i.wdata;
         end
      end
   end

   // status is loaded by hardware whenever the enable is high
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         gwt_status_q <= GWT_READ_RESET;
      end else if (gwt_cfg_ie_i) begin
         gwt_status_q <= gwt_cfg_i;
      end
   end

   // read mux, keys are write-only and fall through to zero
   always_comb begin
      reg_i.rdata = '0;
      if (hit_ctrl) begin
         reg_i.rdata[CLUSTER_RSTN_BIT] = cluster_rstn_q;
         reg_i.rdata[EN_SA_BOOT_BIT]   = en_sa_boot_q;
         reg_i.rdata[FETCH_EN_BIT]     = fetch_en_q;
      end else if (hit_gwt_write) begin
         reg_i.rdata = gwt_cfg_q;
      end else if (hit_gwt_read) begin
         reg_i.rdata = gwt_status_q;
      end
   end

   assign cluster_ctrl_rstn_o  = cluster_rstn_q;
   assign cluster_en_sa_boot_o = en_sa_boot_q;
   assign cluster_fetch_en_o   = fetch_en_q;

   assign key_0_o   = key0_q;
   assign key_1_o   = key1_q;
   assign gwt_cfg_o = gwt_cfg_q;

endmodule

// File: hw/soc_ctrl_top.sv
`timescale 1ns/1ns

module soc_ctrl_top
   import soc_ctrl_bus_pkg::*;
   import soc_ctrl_reg_pkg::*;
#(
   parameter int unsigned APB_ADDR_WIDTH = 32
) (
   input  logic                      clk_i,
   input  logic                      rst_n_i,

   // APB completer port
   input  logic [APB_ADDR_WIDTH-1:0] paddr_i,
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  logic                      pwrite_i,
   input  reg_data_t                 pwdata_i,
   output reg_data_t                 prdata_o,
   output logic                      pready_o,
   output logic                      pslverr_o,

   // cluster control
   output logic                      cluster_ctrl_rstn_o,
   output logic                      cluster_en_sa_boot_o,
   output logic                      cluster_fetch_en_o,

   // logic locking keys
   output key_t                      key_0_o,
   output key_t                      key_1_o,

   // configuration out and status in
   output reg_data_t                 gwt_cfg_o,
   input  reg_data_t                 gwt_cfg_i,
   input  logic                      gwt_cfg_ie_i
);

   reg_bus_if reg_bus (
      .clk_i ( clk_i )
   );

   apb_to_reg_bridge #(
      .APB_ADDR_WIDTH ( APB_ADDR_WIDTH )
   ) i_apb_to_reg_bridge (
      .clk_i     ( clk_i     ),
      .rst_n_i   ( rst_n_i   ),
      .paddr_i   ( paddr_i   ),
      .psel_i    ( psel_i    ),
      .penable_i ( penable_i ),
      .pwrite_i  ( pwrite_i  ),
      .pwdata_i  ( pwdata_i  ),
      .prdata_o  ( prdata_o  ),
      .pready_o  ( pready_o  ),
      .pslverr_o ( pslverr_o ),
      .reg_o     ( reg_bus   )
   );

   soc_ctrl_regfile i_soc_ctrl_regfile (
      .clk_i                ( clk_i                ),
      .rst_n_i              ( rst_n_i              ),
      .reg_i                ( reg_bus              ),
      .cluster_ctrl_rstn_o  ( cluster_ctrl_rstn_o  ),
      .cluster_en_sa_boot_o ( cluster_en_sa_boot_o ),
      .cluster_fetch_en_o   ( cluster_fetch_en_o   ),
      .key_0_o              ( key_0_o              ),
      .key_1_o              ( key_1_o              ),
      .gwt_cfg_o            ( gwt_cfg_o            ),
      .gwt_cfg_i            ( gwt_cfg_i            ),
      .gwt_cfg_ie_i         ( gwt_cfg_ie_i         )
   );

endmodule

// File: verification/soc_ctrl_sva.sv
`timescale 1ns/1ns

module soc_ctrl_sva (
   input logic clk_i,
   input logic rst_n_i,
   input logic psel_i,
   input logic penable_i,
   input logic pready_i,
   input logic pslverr_i,
   input logic valid_i
);

   // number of assertion failures so far
   int unsigned fail_count = 0;

   // one strobe per transfer, so it can never last two cycles
   strobe_single_cycle : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      valid_i |=> !valid_i
   ) else begin
      fail_count++;
      $error("register bus strobe held high for two cycles");
   end

   ready_in_access : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      pready_i |-> (psel_i && penable_i)
   ) else begin
      fail_count++;
      $error("pready high outside an APB access phase");
   end

   slverr_with_ready : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      pslverr_i |-> pready_i
   ) else begin
      fail_count++;
      $error("pslverr high without pready");
   end

   // exactly one wait state after the first access cycle
   one_wait_state : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      $rose(psel_i && penable_i) |=> pready_i
   ) else begin
      fail_count++;
      $error("pready missing in the second access cycle");
   end

endmodule

bind apb_to_reg_bridge soc_ctrl_sva sva_i (
   .clk_i     ( clk_i       ),
   .rst_n_i   ( rst_n_i     ),
   .psel_i    ( psel_i      ),
   .penable_i ( penable_i   ),
   .pready_i  ( pready_o    ),
   .pslverr_i ( pslverr_o   ),
   .valid_i   ( reg_o.valid )
);

// File: verification/soc_ctrl_tb.sv
`timescale 1ns/1ns

module soc_ctrl_tb
   import soc_ctrl_bus_pkg::*;
   import soc_ctrl_reg_pkg::*;
();

   localparam int unsigned APB_ADDR_WIDTH = 32;
   localparam int          MAX_RECORDS    = 64;
   localparam int          READY_TIMEOUT  = 20;

   // op, address, write data, expected read data, expected error
   typedef logic [103:0] record_t;

   logic                      clk;
   logic                      rst_n;
   logic [APB_ADDR_WIDTH-1:0] paddr;
   logic                      psel;
   logic                      penable;
   logic                      pwrite;
   reg_data_t                 pwdata;
   reg_data_t                 prdata;
   logic                      pready;
   logic                      pslverr;
   logic                      cluster_rstn;
   logic                      cluster_sa_boot;
   logic                      cluster_fetch_en;
   key_t                      key_0;
   key_t                      key_1;
   reg_data_t                 gwt_cfg_out;
   reg_data_t                 gwt_cfg_in;
   logic                      gwt_cfg_ie;

   record_t                   patterns [MAX_RECORDS];

   // expected register state, bit 0 reset, bit 1 stand-alone boot, bit 2 fetch enable
   logic [2:0]                exp_ctrl;
   key_t                      exp_key0;
   key_t                      exp_key1;
   reg_data_t                 exp_cfg;
   reg_data_t                 last_status;

   int                        mismatches;
   int                        timeouts;
   int                        bad_records;
   int                        assertion_failures;

   always #20 clk = ~clk;

   soc_ctrl_top #(
      .APB_ADDR_WIDTH ( APB_ADDR_WIDTH )
   ) soc_ctrl_top_i (
      .clk_i                ( clk              ),
      .rst_n_i              ( rst_n            ),
      .paddr_i              ( paddr            ),
      .psel_i               ( psel             ),
      .penable_i            ( penable          ),
      .pwrite_i             ( pwrite           ),
      .pwdata_i             ( pwdata           ),
      .prdata_o             ( prdata           ),
      .pready_o             ( pready           ),
      .pslverr_o            ( pslverr          ),
      .cluster_ctrl_rstn_o  ( cluster_rstn     ),
      .cluster_en_sa_boot_o ( cluster_sa_boot  ),
      .cluster_fetch_en_o   ( cluster_fetch_en ),
      .key_0_o              ( key_0            ),
      .key_1_o              ( key_1            ),
      .gwt_cfg_o            ( gwt_cfg_out      ),
      .gwt_cfg_i            ( gwt_cfg_in       ),
      .gwt_cfg_ie_i         ( gwt_cfg_ie       )
   );

   task automatic check_data(input string what, input reg_data_t got, input reg_data_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_err(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         mismatches++;
         $display("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_key(input string what, input key_t got, input key_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_ctrl(input string what, input logic [2:0] got, input logic [2:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_cycles(input string what, input int got, input int exp);
      if (got != exp) begin
         mismatches++;
         $display("FAIL at %0t ns: %s is %0d cycles, expected %0d", $time, what, got, exp);
      end
   endtask

   // between transfers the APB response is idle
   task automatic check_outputs(input string where);
      check_err({where, " pready"}, pready, 1'b0);
      check_err({where, " pslverr"}, pslverr, 1'b0);
      check_ctrl({where, " cluster control"},
                 {cluster_fetch_en, cluster_sa_boot, cluster_rstn}, exp_ctrl);
      check_key({where, " key 0"}, key_0, exp_key0);
      check_key({where, " key 1"}, key_1, exp_key1);
      check_data({where, " configuration out"}, gwt_cfg_out, exp_cfg);
   endtask

   // only accepted writes reach here, so the offset is word aligned and in the window
   function automatic void update_model(input logic [APB_ADDR_WIDTH-1:0] addr,
                                        input reg_data_t wdata);
      reg_addr_t off;
      off = addr[REG_ADDR_WIDTH-1:0];
      if (off == CTRL_CLUSTER_OFFSET) begin
         exp_ctrl = {wdata[FETCH_EN_BIT], wdata[EN_SA_BOOT_BIT], wdata[CLUSTER_RSTN_BIT]};
      end else if (off == GWT_WRITE_OFFSET) begin
         exp_cfg = wdata;
      end else if (off[7:4] == KEY0_BASE_OFFSET[7:4]) begin
         exp_key0[off[3:2]] = wdata;
      end else if (off[7:4] == KEY1_BASE_OFFSET[7:4]) begin
         exp_key1[off[3:2]] = wdata;
      end
   endfunction

   // one APB transfer, cycles counts access cycles up to and including the one with pready
   task automatic apb_transfer(input logic [APB_ADDR_WIDTH-1:0] addr, input logic wr,
                               input reg_data_t wdata, output reg_data_t rdata,
                               output logic err, output int cycles);
      @(posedge clk);
      #5;
      paddr   = addr;
      pwrite  = wr;
      pwdata  = wdata;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #5;
      penable = 1'b1;
      cycles  = 1;
      while (!pready && cycles <= READY_TIMEOUT) begin
         @(posedge clk);
         #5;
         cycles++;
      end
      rdata = prdata;
      err   = pslverr;
      if (!pready) begin
         timeouts++;
         $display("timeout: no pready within %0d cycles for address %h", READY_TIMEOUT, addr);
      end
      @(posedge clk);
      #5;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic load_status(input reg_data_t value);
      @(posedge clk);
      #5;
      gwt_cfg_in = value;
      gwt_cfg_ie = 1'b1;
      @(posedge clk);
      #5;
      gwt_cfg_ie  = 1'b0;
      last_status = value;
   endtask

   initial begin
      record_t                   rec;
      logic [3:0]                op;
      logic [APB_ADDR_WIDTH-1:0] addr;
      reg_data_t                 wdata;
      reg_data_t                 exp_rdata;
      reg_data_t                 rdata;
      logic                      exp_err;
      logic                      err;
      logic                      at_end;
      int                        cycles;
      int                        idx;
      int                        records_run;

      void'($urandom(32'h8ec3));
      clk         = 1'b0;
      rst_n       = 1'b0;
      paddr       = '0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      pwdata      = '0;
      gwt_cfg_in  = '0;
      gwt_cfg_ie  = 1'b0;
      exp_ctrl    = '0;
      exp_key0    = '0;
      exp_key1    = '0;
      exp_cfg     = '0;
      last_status = '0;
      mismatches  = 0;
      timeouts    = 0;
      bad_records = 0;
      assertion_failures = 0;
      records_run = 0;
      at_end      = 1'b0;
      idx         = 0;

      $readmemh("verification/soc_ctrl_patterns.txt", patterns);

      repeat (16) @(posedge clk);
      #5;
      rst_n = 1'b1;
      check_outputs("after reset");

      while (idx < MAX_RECORDS && !at_end) begin
         rec       = patterns[idx];
         op        = rec[103:100];
         addr      = rec[99:68];
         wdata     = rec[67:36];
         exp_rdata = rec[35:4];
         exp_err   = rec[0];
         case (op)
            4'h0: at_end = 1'b1;
            4'h1, 4'h2, 4'h3: begin
               apb_transfer(addr, op == 4'h1, wdata, rdata, err, cycles);
               check_cycles($sformatf("record %0d latency", idx), cycles, 2);
               check_err($sformatf("record %0d pslverr", idx), err, exp_err);
               if (op == 4'h2) begin
                  check_data($sformatf("record %0d read data", idx), rdata, exp_rdata);
               end else if (op == 4'h3) begin
                  check_data($sformatf("record %0d status read", idx), rdata, last_status);
               end
               if (op == 4'h1 && !exp_err) begin
                  update_model(addr, wdata);
               end
            end
            4'h4: load_status(wdata);
            4'h5: load_status($urandom());
            default: begin
               bad_records++;
               $display("pattern record %0d has an unknown operation %h", idx, op);
               at_end = 1'b1;
            end
         endcase
         if (!at_end) begin
            check_outputs($sformatf("record %0d", idx));
            records_run++;
         end
         idx++;
      end

      if (records_run == 0) begin
         bad_records++;
         $display("no pattern records were run, the pattern file may be missing");
      end

      assertion_failures = soc_ctrl_top_i.i_apb_to_reg_bridge.sva_i.fail_count;

      $display("errors: %0d mismatches, %0d timeouts, %0d pattern problems, %0d assertion failures",
               mismatches, timeouts, bad_records, assertion_failures);
      if (mismatches + timeouts + bad_records + assertion_failures == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: verification/soc_ctrl_patterns.txt
// op_addr_wdata_rdata_err, one APB transfer or status load per record
// op 1 write, 2 read, 3 read of the last loaded status, 4 load wdata, 5 load random, 0 end
// every mapped register reads zero after reset
2_00000000_00000000_00000000_0
2_00000004_00000000_00000000_0
2_00000008_00000000_00000000_0
2_00000010_00000000_00000000_0
2_0000001C_00000000_00000000_0
2_00000020_00000000_00000000_0
2_0000002C_00000000_00000000_0
// cluster control keeps bits 2:0 only
1_00000000_FFFFFFFD_00000000_0
2_00000000_00000000_00000005_0
1_00000000_00000002_00000000_0
2_00000000_00000000_00000002_0
1_00000000_00000007_00000000_0
2_00000000_00000000_00000007_0
// both keys, word 0 at the lowest offset
1_00000010_11111111_00000000_0
1_00000014_22222222_00000000_0
1_00000018_33333333_00000000_0
1_0000001C_44444444_00000000_0
1_00000020_A5A5A5A5_00000000_0
1_00000024_5A5A5A5A_00000000_0
1_00000028_DEADBEEF_00000000_0
1_0000002C_0BADF00D_00000000_0
2_00000014_00000000_00000000_0
2_00000028_00000000_00000000_0
// configuration out and status in
1_00000004_CAFE1234_00000000_0
2_00000004_00000000_CAFE1234_0
4_00000000_12345678_00000000_0
2_00000008_00000000_12345678_0
5_00000000_00000000_00000000_0
3_00000008_00000000_00000000_0
5_00000000_00000000_00000000_0
3_00000008_00000000_00000000_0
// rejected accesses change nothing
1_00000040_FFFFFFFF_00000000_1
2_00000030_00000000_00000000_1
1_00000008_FFFFFFFF_00000000_1
3_00000008_00000000_00000000_0
1_00000002_FFFFFFFF_00000000_1
2_00000006_00000000_00000000_1
1_00000100_FFFFFFFF_00000000_1
1_80000010_FFFFFFFF_00000000_1
2_00000000_00000000_00000007_0
2_00000004_00000000_CAFE1234_0
0_00000000_00000000_00000000_0

// File: build.f
hw/soc_ctrl_bus_pkg.sv
hw/soc_ctrl_reg_pkg.sv
hw/reg_bus_if.sv
hw/apb_to_reg_bridge.sv
hw/soc_ctrl_regfile.sv
hw/soc_ctrl_top.sv
verification/soc_ctrl_sva.sv
verification/soc_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the SoC control block testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module soc_ctrl_tb \
   -f build.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator compile failed with status $status"
   exit 1
fi

./obj_dir/Vsoc_ctrl_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# the testbench prints its verdict, a failing run leaves the fail message in the log
if grep -q "TEST FAIL" "$LOG"; then
   echo "simulation reported a failure"
   exit 1
fi

echo "simulation finished without a reported failure"
exit 0
